/* verilog/fft_num_pkg.sv */
`default_nettype none

// Numeric types shared by the butterfly datapath and the register block
package fft_num_pkg;

    // ========================================
    // Default widths
    // ========================================

    // Width of one real or imaginary component
    localparam int DATA_W = 16;

    // Twiddle factors are Q1.15
    localparam int TWIDDLE_FRAC = 15;

    // Lanes instantiated by the top level unless overridden
    localparam int NUM_LANES_DEF = 4;

    // ========================================
    // Complex data
    // ========================================

    // One signed component in two's complement
    typedef logic signed [DATA_W-1:0] comp_t;

    // Real part in the upper half, imaginary part in the lower half
    typedef struct packed {
        comp_t re;
        comp_t im;
    } cplx_t;

endpackage

`default_nettype wire

/* verilog/fft_regmap_pkg.sv */
`default_nettype none

// APB register map of the butterfly accelerator
package fft_regmap_pkg;

    localparam int ADDR_W = 12;

    // ========================================
    // Global registers
    // ========================================
    localparam logic [ADDR_W-1:0] CTRL_ADDR      = 12'h000;
    localparam logic [ADDR_W-1:0] STATUS_ADDR    = 12'h004;
    localparam logic [ADDR_W-1:0] SCALE_ADDR     = 12'h008;
    localparam logic [ADDR_W-1:0] OVF_COUNT_ADDR = 12'h00C;
    localparam logic [ADDR_W-1:0] OVF_LANES_ADDR = 12'h010;

    // ========================================
    // Per-lane window
    // ========================================
    localparam logic [ADDR_W-1:0] LANE_BASE   = 12'h100;
    localparam logic [ADDR_W-1:0] LANE_STRIDE = 12'h020;

    // Offsets inside one lane window
    localparam logic [ADDR_W-1:0] LANE_A_OFS    = 12'h000;
    localparam logic [ADDR_W-1:0] LANE_B_OFS    = 12'h004;
    localparam logic [ADDR_W-1:0] LANE_W_OFS    = 12'h008;
    localparam logic [ADDR_W-1:0] LANE_X_OFS    = 12'h00C;
    localparam logic [ADDR_W-1:0] LANE_Y_OFS    = 12'h010;
    localparam logic [ADDR_W-1:0] LANE_FLAG_OFS = 12'h014;

    // CTRL fields
    localparam int CTRL_START_BIT   = 0;
    localparam int CTRL_RESCALE_BIT = 1;
    localparam int CTRL_CLEAR_BIT   = 2;

    // STATUS fields
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // Decoded register kind
    typedef enum logic [3:0] {
        SEL_CTRL,
        SEL_STATUS,
        SEL_SCALE,
        SEL_OVF_COUNT,
        SEL_OVF_LANES,
        SEL_LANE_A,
        SEL_LANE_B,
        SEL_LANE_W,
        SEL_LANE_X,
        SEL_LANE_Y,
        SEL_LANE_FLAG,
        SEL_NONE
    } reg_sel_e;

endpackage

`default_nettype wire

/* verilog/fft_apb_regs.sv */
`default_nettype none

module fft_apb_regs #(
    parameter int NUM_LANES = 4,
    parameter int DATA_W    = 16
) (
    input  logic                                 clk_i,
    input  logic                                 reset_n_i,
    // APB slave, zero wait states
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    input  logic                                 pwrite_i,
    input  logic [fft_regmap_pkg::ADDR_W-1:0]    paddr_i,
    input  fft_num_pkg::cplx_t                   pwdata_i,
    output fft_num_pkg::cplx_t                   prdata_o,
    // Results and statistics from the tracker
    input  fft_num_pkg::cplx_t [NUM_LANES-1:0]   x_i,
    input  fft_num_pkg::cplx_t [NUM_LANES-1:0]   y_i,
    input  logic [NUM_LANES-1:0]                 ovf_lanes_i,
    input  logic [7:0]                           scale_factor_i,
    input  logic [7:0]                           ovf_count_i,
    input  logic                                 done_i,
    input  logic                                 op_done_i,
    // Operands and control to the lanes
    output fft_num_pkg::cplx_t [NUM_LANES-1:0]   a_o,
    output fft_num_pkg::cplx_t [NUM_LANES-1:0]   b_o,
    output fft_num_pkg::cplx_t [NUM_LANES-1:0]   w_o,
    output logic                                 start_o,
    output logic                                 rescale_en_o,
    output logic                                 clear_o
);

    localparam int AW         = fft_regmap_pkg::ADDR_W;
    localparam int WORD_W     = 2 * DATA_W;
    localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    fft_regmap_pkg::reg_sel_e sel;
    logic [LANE_IDX_W-1:0]    lane_idx;
    logic [AW-1:0]            lane_off;
    logic [AW-1:0]            lane_num;
    logic [AW-1:0]            field_off;
    logic [WORD_W-1:0]        wdata;
    logic [WORD_W-1:0]        rdata;
    logic                     wr_en;
    logic [3:0]               inflight_q;
    logic                     busy;

    assign wdata = pwdata_i;
    assign wr_en = psel_i & penable_i & pwrite_i;
    assign busy  = (inflight_q != '0);

    // ========================================
    // Address decode
    // ========================================
    always_comb begin
        lane_off  = paddr_i - fft_regmap_pkg::LANE_BASE;
        lane_num  = lane_off / fft_regmap_pkg::LANE_STRIDE;
        field_off = lane_off % fft_regmap_pkg::LANE_STRIDE;
        lane_idx  = LANE_IDX_W'(lane_num);
        sel       = fft_regmap_pkg::SEL_NONE;
        if (paddr_i >= fft_regmap_pkg::LANE_BASE && lane_num < AW'(NUM_LANES)) begin
            case (field_off)
                fft_regmap_pkg::LANE_A_OFS:    sel = fft_regmap_pkg::SEL_LANE_A;
                fft_regmap_pkg::LANE_B_OFS:    sel = fft_regmap_pkg::SEL_LANE_B;
                fft_regmap_pkg::LANE_W_OFS:    sel = fft_regmap_pkg::SEL_LANE_W;
                fft_regmap_pkg::LANE_X_OFS:    sel = fft_regmap_pkg::SEL_LANE_X;
                fft_regmap_pkg::LANE_Y_OFS:    sel = fft_regmap_pkg::SEL_LANE_Y;
                fft_regmap_pkg::LANE_FLAG_OFS: sel = fft_regmap_pkg::SEL_LANE_FLAG;
                default:                       sel = fft_regmap_pkg::SEL_NONE;
            endcase
        end else begin
            case (paddr_i)
                fft_regmap_pkg::CTRL_ADDR:      sel = fft_regmap_pkg::SEL_CTRL;
                fft_regmap_pkg::STATUS_ADDR:    sel = fft_regmap_pkg::SEL_STATUS;
                fft_regmap_pkg::SCALE_ADDR:     sel = fft_regmap_pkg::SEL_SCALE;
                fft_regmap_pkg::OVF_COUNT_ADDR: sel = fft_regmap_pkg::SEL_OVF_COUNT;
                fft_regmap_pkg::OVF_LANES_ADDR: sel = fft_regmap_pkg::SEL_OVF_LANES;
                default:                        sel = fft_regmap_pkg::SEL_NONE;
            endcase
        end
    end

    // Control pulses and the rescale level, all taken from one CTRL write
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            start_o      <= 1'b0;
            clear_o      <= 1'b0;
            rescale_en_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            clear_o <= 1'b0;
            if (wr_en && sel == fft_regmap_pkg::SEL_CTRL) begin
                start_o <= wdata[fft_regmap_pkg::CTRL_START_BIT];
                clear_o <= wdata[fft_regmap_pkg::CTRL_CLEAR_BIT];
                if (wdata[fft_regmap_pkg::CTRL_START_BIT]) begin
                    rescale_en_o <= wdata[fft_regmap_pkg::CTRL_RESCALE_BIT];
                end
            end
        end
    end

    // Operand storage
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            case (sel)
                fft_regmap_pkg::SEL_LANE_A: a_o[lane_idx] <= pwdata_i;
                fft_regmap_pkg::SEL_LANE_B: b_o[lane_idx] <= pwdata_i;
                fft_regmap_pkg::SEL_LANE_W: w_o[lane_idx] <= pwdata_i;
                default: ;
            endcase
        end
    end

    // Operations between start and op_done
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            inflight_q <= '0;
        end else begin
            case ({start_o, op_done_i})
                2'b10:   inflight_q <= inflight_q + 4'd1;
                2'b01:   inflight_q <= inflight_q - 4'd1;
                default: inflight_q <= inflight_q;
            endcase
        end
    end

    // ========================================
    // Read mux
    // ========================================
    always_comb begin
        rdata = '0;
        if (psel_i) begin
            case (sel)
                fft_regmap_pkg::SEL_CTRL: begin
                    rdata[fft_regmap_pkg::CTRL_RESCALE_BIT] = rescale_en_o;
                end
                fft_regmap_pkg::SEL_STATUS: begin
                    rdata[fft_regmap_pkg::STATUS_BUSY_BIT] = busy;
                    rdata[fft_regmap_pkg::STATUS_DONE_BIT] = done_i;
                end
                fft_regmap_pkg::SEL_SCALE:     rdata[7:0] = scale_factor_i;
                fft_regmap_pkg::SEL_OVF_COUNT: rdata[7:0] = ovf_count_i;
                fft_regmap_pkg::SEL_OVF_LANES: rdata[NUM_LANES-1:0] = ovf_lanes_i;
                fft_regmap_pkg::SEL_LANE_A:    rdata = a_o[lane_idx];
                fft_regmap_pkg::SEL_LANE_B:    rdata = b_o[lane_idx];
                fft_regmap_pkg::SEL_LANE_W:    rdata = w_o[lane_idx];
                fft_regmap_pkg::SEL_LANE_X:    rdata = x_i[lane_idx];
                fft_regmap_pkg::SEL_LANE_Y:    rdata = y_i[lane_idx];
                fft_regmap_pkg::SEL_LANE_FLAG: rdata[0] = ovf_lanes_i[lane_idx];
                default:                       rdata = '0;
            endcase
        end
    end

    assign prdata_o = rdata;

endmodule

`default_nettype wire

/* verilog/fft_butterfly.sv */
`default_nettype none

module fft_butterfly #(
    parameter int DATA_W = 16
) (
    input  logic               clk_i,
    input  logic               reset_n_i,
    input  logic               start_i,
    input  logic               rescale_en_i,
    input  fft_num_pkg::cplx_t a_i,
    input  fft_num_pkg::cplx_t b_i,
    input  fft_num_pkg::cplx_t w_i,
    output logic               valid_o,
    output fft_num_pkg::cplx_t x_o,
    output fft_num_pkg::cplx_t y_o,
    output logic               ovf_o
);

    localparam int PROD_W = 2 * DATA_W + 1;

    // Valid and rescale travel alongside the data
    logic s1_valid;
    logic s1_rescale;
    logic s2_valid;
    logic s2_rescale;

    // Stage 1 data
    logic signed [DATA_W-1:0] s1_sum_re;
    logic signed [DATA_W-1:0] s1_sum_im;
    logic signed [DATA_W-1:0] s1_dif_re;
    logic signed [DATA_W-1:0] s1_dif_im;
    logic signed [DATA_W-1:0] s1_w_re;
    logic signed [DATA_W-1:0] s1_w_im;

    // Stage 2 data
    logic signed [PROD_W-1:0] mul_re;
    logic signed [PROD_W-1:0] mul_im;
    logic signed [DATA_W-1:0] s2_x_re;
    logic signed [DATA_W-1:0] s2_x_im;
    logic signed [DATA_W-1:0] s2_y_re;
    logic signed [DATA_W-1:0] s2_y_im;

    logic any_ovf;
    logic do_shift;

    // Result no longer fits after the extra bit of butterfly growth
    function automatic logic top_bits_differ(input logic [DATA_W-1:0] c);
        return c[DATA_W-1] ^ c[DATA_W-2];
    endfunction

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            s1_valid   <= 1'b0;
            s1_rescale <= 1'b0;
            s2_valid   <= 1'b0;
            s2_rescale <= 1'b0;
            valid_o    <= 1'b0;
            ovf_o      <= 1'b0;
        end else begin
            s1_valid <= start_i;
            if (start_i) begin
                s1_rescale <= rescale_en_i;
            end
            s2_valid   <= s1_valid;
            s2_rescale <= s1_rescale;
            valid_o    <= s2_valid;
            ovf_o      <= s2_valid & do_shift;
        end
    end

    // ========================================
    // Stage 1: sum and difference, wrapping
    // ========================================
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            s1_sum_re <= a_i.re + b_i.re;
            s1_sum_im <= a_i.im + b_i.im;
            s1_dif_re <= a_i.re - b_i.re;
            s1_dif_im <= a_i.im - b_i.im;
            s1_w_re   <= w_i.re;
            s1_w_im   <= w_i.im;
        end
    end

    // ========================================
    // Stage 2: (A-B)*W in Q1.15
    // ========================================
    always_comb begin
        mul_re = s1_dif_re * s1_w_re - s1_dif_im * s1_w_im;
        mul_im = s1_dif_re * s1_w_im + s1_dif_im * s1_w_re;
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid) begin
            s2_x_re <= s1_sum_re;
            s2_x_im <= s1_sum_im;
            // Arithmetic shift by the fraction width, low bits kept
            s2_y_re <= mul_re[fft_num_pkg::TWIDDLE_FRAC +: DATA_W];
            s2_y_im <= mul_im[fft_num_pkg::TWIDDLE_FRAC +: DATA_W];
        end
    end

    // ========================================
    // Stage 3: overflow check and rescale
    // ========================================
    assign any_ovf = top_bits_differ(s2_x_re) | top_bits_differ(s2_x_im)
                   | top_bits_differ(s2_y_re) | top_bits_differ(s2_y_im);
    assign do_shift = s2_rescale & any_ovf;

    always_ff @(posedge clk_i) begin
        if (s2_valid) begin
            x_o.re <= do_shift ? (s2_x_re >>> 1) : s2_x_re;
            x_o.im <= do_shift ? (s2_x_im >>> 1) : s2_x_im;
            y_o.re <= do_shift ? (s2_y_re >>> 1) : s2_y_re;
            y_o.im <= do_shift ? (s2_y_im >>> 1) : s2_y_im;
        end
    end

endmodule

`default_nettype wire

/* verilog/fft_scale_tracker.sv */
`default_nettype none

module fft_scale_tracker #(
    parameter int NUM_LANES = 4
) (
    input  logic                               clk_i,
    input  logic                               reset_n_i,
    input  logic                               clear_i,
    input  logic                               start_i,
    input  logic [NUM_LANES-1:0]               lane_valid_i,
    input  logic [NUM_LANES-1:0]               lane_ovf_i,
    input  fft_num_pkg::cplx_t [NUM_LANES-1:0] lane_x_i,
    input  fft_num_pkg::cplx_t [NUM_LANES-1:0] lane_y_i,
    output fft_num_pkg::cplx_t [NUM_LANES-1:0] x_o,
    output fft_num_pkg::cplx_t [NUM_LANES-1:0] y_o,
    output logic [NUM_LANES-1:0]               ovf_lanes_o,
    output logic [7:0]                         scale_factor_o,
    output logic [7:0]                         ovf_count_o,
    output logic                               done_o,
    output logic                               op_done_o
);

    typedef enum logic {
        TRK_IDLE,
        TRK_DRAIN
    } trk_state_e;

    trk_state_e state_q;
    trk_state_e state_d;
    logic [2:0] pending_q;
    logic [2:0] pending_d;
    logic       capture;
    logic [8:0] flag_cnt;
    logic [8:0] cnt_sum;

    // Lanes run in lockstep, so one capture covers all of them
    assign capture = (state_q == TRK_DRAIN) & (&lane_valid_i);

    always_comb begin
        pending_d = pending_q + 3'(start_i) - 3'(capture);
        state_d   = (pending_d != '0) ? TRK_DRAIN : TRK_IDLE;
    end

    // Flagged lanes in this operation
    always_comb begin
        flag_cnt = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            flag_cnt = flag_cnt + 9'(lane_ovf_i[i]);
        end
        cnt_sum = {1'b0, ovf_count_o} + flag_cnt;
    end

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_q        <= TRK_IDLE;
            pending_q      <= '0;
            ovf_lanes_o    <= '0;
            scale_factor_o <= '0;
            ovf_count_o    <= '0;
            done_o         <= 1'b0;
            op_done_o      <= 1'b0;
        end else begin
            state_q   <= state_d;
            pending_q <= pending_d;
            op_done_o <= capture;
            if (start_i) begin
                done_o <= 1'b0;
            end else if (capture) begin
                done_o <= 1'b1;
            end
            if (capture) begin
                ovf_lanes_o <= lane_ovf_i;
            end
            if (clear_i) begin
                scale_factor_o <= '0;
                ovf_count_o    <= '0;
            end else if (capture) begin
                scale_factor_o <= scale_factor_o + 8'(|lane_ovf_i);
                // Saturates at 255
                ovf_count_o <= cnt_sum[8] ? 8'hFF : cnt_sum[7:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            x_o <= lane_x_i;
            y_o <= lane_y_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/fft_bfly_top.sv */
`default_nettype none

module fft_bfly_top #(
    parameter int NUM_LANES = fft_num_pkg::NUM_LANES_DEF,
    parameter int DATA_W    = fft_num_pkg::DATA_W
) (
    input  logic                              clk_i,
    input  logic                              reset_n_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [fft_regmap_pkg::ADDR_W-1:0] paddr_i,
    input  fft_num_pkg::cplx_t                pwdata_i,
    output fft_num_pkg::cplx_t                prdata_o
);

    // Register block to lanes
    fft_num_pkg::cplx_t [NUM_LANES-1:0] lane_a;
    fft_num_pkg::cplx_t [NUM_LANES-1:0] lane_b;
    fft_num_pkg::cplx_t [NUM_LANES-1:0] lane_w;
    logic                               start;
    logic                               rescale_en;
    logic                               clear;

    // Lanes to tracker
    logic [NUM_LANES-1:0]               lane_valid;
    logic [NUM_LANES-1:0]               lane_ovf;
    fft_num_pkg::cplx_t [NUM_LANES-1:0] lane_x;
    fft_num_pkg::cplx_t [NUM_LANES-1:0] lane_y;

    // Tracker to register block
    fft_num_pkg::cplx_t [NUM_LANES-1:0] res_x;
    fft_num_pkg::cplx_t [NUM_LANES-1:0] res_y;
    logic [NUM_LANES-1:0]               ovf_lanes;
    logic [7:0]                         scale_factor;
    logic [7:0]                         ovf_count;
    logic                               done;
    logic                               op_done;

    fft_apb_regs #(
        .NUM_LANES (NUM_LANES),
        .DATA_W    (DATA_W)
    ) u_regs (
        .clk_i          (clk_i),
        .reset_n_i      (reset_n_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .x_i            (res_x),
        .y_i            (res_y),
        .ovf_lanes_i    (ovf_lanes),
        .scale_factor_i (scale_factor),
        .ovf_count_i    (ovf_count),
        .done_i         (done),
        .op_done_i      (op_done),
        .a_o            (lane_a),
        .b_o            (lane_b),
        .w_o            (lane_w),
        .start_o        (start),
        .rescale_en_o   (rescale_en),
        .clear_o        (clear)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : u_lane
        fft_butterfly #(
            .DATA_W (DATA_W)
        ) u_bfly (
            .clk_i        (clk_i),
            .reset_n_i    (reset_n_i),
            .start_i      (start),
            .rescale_en_i (rescale_en),
            .a_i          (lane_a[i]),
            .b_i          (lane_b[i]),
            .w_i          (lane_w[i]),
            .valid_o      (lane_valid[i]),
            .x_o          (lane_x[i]),
            .y_o          (lane_y[i]),
            .ovf_o        (lane_ovf[i])
        );
    end

    fft_scale_tracker #(
        .NUM_LANES (NUM_LANES)
    ) u_tracker (
        .clk_i          (clk_i),
        .reset_n_i      (reset_n_i),
        .clear_i        (clear),
        .start_i        (start),
        .lane_valid_i   (lane_valid),
        .lane_ovf_i     (lane_ovf),
        .lane_x_i       (lane_x),
        .lane_y_i       (lane_y),
        .x_o            (res_x),
        .y_o            (res_y),
        .ovf_lanes_o    (ovf_lanes),
        .scale_factor_o (scale_factor),
        .ovf_count_o    (ovf_count),
        .done_o         (done),
        .op_done_o      (op_done)
    );

endmodule

`default_nettype wire

/* tests/fft_bfly_assert.sv */
`default_nettype none

module fft_bfly_assert #(
    parameter int NUM_LANES = 4
) (
    input wire logic                 clk_i,
    input wire logic                 reset_n_i,
    input wire logic                 start_i,
    input wire logic                 clear_i,
    input wire logic                 busy_i,
    input wire logic [NUM_LANES-1:0] lane_valid_i,
    input wire logic [7:0]           ovf_count_i
);

    // ========================================
    // Properties
    // ========================================
    lane_latency: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        start_i |-> ##3 (&lane_valid_i))
        else $error("lane valid did not follow start after 3 cycles");

    // An operation completes 4 cycles after its start, so busy ends within that window
    idle_not_busy: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !($past(start_i, 1) || $past(start_i, 2) || $past(start_i, 3) || $past(start_i, 4))
        |-> !busy_i)
        else $error("busy high with no operation in flight");

    count_monotonic: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !clear_i |=> (ovf_count_i >= $past(ovf_count_i)))
        else $error("overflow count decreased without clear");

    start_single: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        start_i |=> !start_i)
        else $error("start pulse longer than one cycle");

endmodule

bind fft_bfly_top fft_bfly_assert #(.NUM_LANES(NUM_LANES)) u_assert (
    .clk_i        (clk_i),
    .reset_n_i    (reset_n_i),
    .start_i      (start),
    .clear_i      (clear),
    .busy_i       (u_regs.busy),
    .lane_valid_i (lane_valid),
    .ovf_count_i  (ovf_count)
);

`default_nettype wire

/* tests/tb_fft_bfly.sv */
`default_nettype none

module tb_fft_bfly;

    localparam int NUM_LANES      = fft_num_pkg::NUM_LANES_DEF;
    localparam int NUM_OPS        = 4;
    localparam int FIELDS         = 8;
    localparam int HALF_PERIOD    = 5;
    localparam int RESET_CYCLES   = 10;
    // Back-to-back operation counts twice
    localparam int TIMEOUT_CYCLES = (NUM_OPS + 1) * 200 + RESET_CYCLES;

    // Columns of one data line
    localparam int F_RESCALE = 0;
    localparam int F_LANE    = 1;
    localparam int F_A       = 2;
    localparam int F_B       = 3;
    localparam int F_W       = 4;
    localparam int F_X       = 5;
    localparam int F_Y       = 6;
    localparam int F_FLAG    = 7;

    logic                              clk_i;
    logic                              reset_n_i;
    logic                              psel_i;
    logic                              penable_i;
    logic                              pwrite_i;
    logic [fft_regmap_pkg::ADDR_W-1:0] paddr_i;
    fft_num_pkg::cplx_t                pwdata_i;
    fft_num_pkg::cplx_t                prdata_o;

    logic [31:0] td [0:NUM_OPS*NUM_LANES*FIELDS-1];
    int          exp_scale;
    int          exp_count;

    fft_bfly_top u_dut (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD clk_i = ~clk_i;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout: the test did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    function automatic int data_index(input int op, input int lane, input int field);
        return (op * NUM_LANES + lane) * FIELDS + field;
    endfunction

    function automatic logic [11:0] lane_addr(input int lane, input logic [11:0] ofs);
        return fft_regmap_pkg::LANE_BASE + 12'(lane) * fft_regmap_pkg::LANE_STRIDE + ofs;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_cplx(input string name, input fft_num_pkg::cplx_t got,
                              input fft_num_pkg::cplx_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flags(input string name, input logic [NUM_LANES-1:0] got,
                               input logic [NUM_LANES-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // ========================================
    // APB master
    // ========================================
    task automatic idle_gap();
        repeat ($urandom % 3) @(posedge clk_i);
    endtask

    task automatic apb_write(input logic [11:0] addr, input fft_num_pkg::cplx_t data);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b1;
        paddr_i   <= addr;
        pwdata_i  <= data;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output fft_num_pkg::cplx_t data);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= addr;
        @(posedge clk_i);
        penable_i <= 1'b1;
        // Read data settles well before the falling edge
        @(negedge clk_i);
        data = prdata_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic wait_done();
        fft_num_pkg::cplx_t st;
        do begin
            apb_read(fft_regmap_pkg::STATUS_ADDR, st);
        end while (st[0] !== 1'b0 || st[1] !== 1'b1);
    endtask

    task automatic check_stats(input logic [NUM_LANES-1:0] exp_mask);
        fft_num_pkg::cplx_t rd;
        apb_read(fft_regmap_pkg::OVF_LANES_ADDR, rd);
        check_flags("OVF_LANES", rd[NUM_LANES-1:0], exp_mask);
        apb_read(fft_regmap_pkg::SCALE_ADDR, rd);
        check_byte("SCALE", rd[7:0], 8'(exp_scale));
        apb_read(fft_regmap_pkg::OVF_COUNT_ADDR, rd);
        check_byte("OVF_COUNT", rd[7:0], 8'(exp_count));
    endtask

    // Load one operation, start it the given number of times, check the results
    // Earlier starts run without rescale, so only the last one can flag lanes
    task automatic run_op(input int op, input int starts);
        fft_num_pkg::cplx_t   rd;
        logic [31:0]          ctrl;
        logic [NUM_LANES-1:0] mask;
        int                   flagged;
        mask    = '0;
        flagged = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (td[data_index(op, l, F_LANE)] != 32'(l)) begin
                $display("Test data line for operation %0d is out of lane order", op);
                stop_on_error();
            end
            apb_write(lane_addr(l, fft_regmap_pkg::LANE_A_OFS), td[data_index(op, l, F_A)]);
            idle_gap();
            apb_write(lane_addr(l, fft_regmap_pkg::LANE_B_OFS), td[data_index(op, l, F_B)]);
            apb_write(lane_addr(l, fft_regmap_pkg::LANE_W_OFS), td[data_index(op, l, F_W)]);
            idle_gap();
            mask[l] = td[data_index(op, l, F_FLAG)][0];
            flagged = flagged + int'(mask[l]);
        end
        // Operand read back
        for (int l = 0; l < NUM_LANES; l++) begin
            apb_read(lane_addr(l, fft_regmap_pkg::LANE_A_OFS), rd);
            check_cplx($sformatf("lane%0d A", l), rd, td[data_index(op, l, F_A)]);
            apb_read(lane_addr(l, fft_regmap_pkg::LANE_B_OFS), rd);
            check_cplx($sformatf("lane%0d B", l), rd, td[data_index(op, l, F_B)]);
            apb_read(lane_addr(l, fft_regmap_pkg::LANE_W_OFS), rd);
            check_cplx($sformatf("lane%0d W", l), rd, td[data_index(op, l, F_W)]);
        end
        ctrl = '0;
        ctrl[fft_regmap_pkg::CTRL_START_BIT] = 1'b1;
        for (int s = 0; s < starts; s++) begin
            if (s == starts - 1) begin
                ctrl[fft_regmap_pkg::CTRL_RESCALE_BIT] = td[data_index(op, 0, F_RESCALE)][0];
            end
            apb_write(fft_regmap_pkg::CTRL_ADDR, ctrl);
        end
        wait_done();
        // Statistics model
        if (mask != '0) begin
            exp_scale = exp_scale + 1;
        end
        exp_count = (exp_count + flagged > 255) ? 255 : exp_count + flagged;
        for (int l = 0; l < NUM_LANES; l++) begin
            apb_read(lane_addr(l, fft_regmap_pkg::LANE_X_OFS), rd);
            check_cplx($sformatf("lane%0d X", l), rd, td[data_index(op, l, F_X)]);
            apb_read(lane_addr(l, fft_regmap_pkg::LANE_Y_OFS), rd);
            check_cplx($sformatf("lane%0d Y", l), rd, td[data_index(op, l, F_Y)]);
            apb_read(lane_addr(l, fft_regmap_pkg::LANE_FLAG_OFS), rd);
            check_byte($sformatf("lane%0d FLAG", l), rd[7:0], {7'b0, mask[l]});
        end
        check_stats(mask);
        apb_read(fft_regmap_pkg::STATUS_ADDR, rd);
        check_byte("STATUS", rd[7:0], 8'h02);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        fft_num_pkg::cplx_t rd;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        reset_n_i = 1'b0;
        exp_scale = 0;
        exp_count = 0;
        void'($urandom(76440));
        $readmemh("tests/fft_testdata.hex", td);
        if (^td[NUM_OPS*NUM_LANES*FIELDS-1] === 1'bx) begin
            $display("Test data file is missing or too short");
            stop_on_error();
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_n_i <= 1'b1;

        // Idle state after reset
        apb_read(fft_regmap_pkg::STATUS_ADDR, rd);
        check_byte("STATUS", rd[7:0], 8'h00);
        check_stats('0);

        run_op(0, 1);
        run_op(1, 1);
        run_op(2, 1);

        // Clear the statistics
        apb_write(fft_regmap_pkg::CTRL_ADDR, 32'(1 << fft_regmap_pkg::CTRL_CLEAR_BIT));
        exp_scale = 0;
        exp_count = 0;
        apb_read(fft_regmap_pkg::SCALE_ADDR, rd);
        check_byte("SCALE", rd[7:0], 8'h00);
        apb_read(fft_regmap_pkg::OVF_COUNT_ADDR, rd);
        check_byte("OVF_COUNT", rd[7:0], 8'h00);

        // Two starts with no gap between them
        run_op(3, 2);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
verilog/fft_num_pkg.sv
verilog/fft_regmap_pkg.sv
verilog/fft_apb_regs.sv
verilog/fft_butterfly.sv
verilog/fft_scale_tracker.sv
verilog/fft_bfly_top.sv
tests/fft_bfly_assert.sv
tests/tb_fft_bfly.sv

/* run.sh */
#!/bin/sh
# Build and run the butterfly accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_fft_bfly \
    -o sim_fft_bfly > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_fft_bfly > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

/* tests/fft_testdata.hex */
// rescale lane A B W X Y flag (complex words are re:im, 16 bits each)
// Four lines make one operation, lanes 0 to 3 in order
0 0 01000200 00800040 40000000 01800240 004000E0 0
0 1 1000F000 08000800 00004000 1800F800 0C000400 0
0 2 70000000 30000000 7FFF0000 A0000000 3FFF0000 0
0 3 00000000 00000000 00000000 00000000 00000000 0
1 0 70000000 30000000 7FFF0000 D0000000 1FFF0000 1
1 1 30000000 D0000000 7FFF0000 00000000 2FFF0000 1
1 2 01000200 00800040 40000000 01800240 004000E0 0
1 3 0000B000 0000B000 00000000 00003000 00000000 1
1 0 70000000 30000000 7FFF0000 D0000000 1FFF0000 1
1 1 00000000 00000000 00000000 00000000 00000000 0
1 2 00000000 00000000 00000000 00000000 00000000 0
1 3 00000000 00000000 00000000 00000000 00000000 0
1 0 1000F000 08000800 00004000 1800F800 0C000400 0
1 1 30000000 D0000000 7FFF0000 00000000 2FFF0000 1
1 2 01000200 00800040 40000000 01800240 004000E0 0
1 3 00000000 00000000 00000000 00000000 00000000 0
